//--- build.f
cpu_pkg.sv
alu.sv
register_file.sv
idecoder.sv
cpu.sv
tb_clk_gen.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - alu.sv
  - register_file.sv
  - idecoder.sv
  - cpu.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int BITS        = 16;
    localparam int NUM_PROGS   = 5;    // last one carries an illegal opcode
    localparam int FLASH_DEPTH = 64;   // programs are at most 40 words
    localparam int TRACE_MAX   = 256;
    localparam int HALT_WIN    = 8;    // cycles watched after the halt
    localparam int WATCHDOG_NS = NUM_PROGS * 40 * 5 * 100 + NUM_PROGS * 2000 + 5000;

    logic              clk;
    logic              reset;
    logic [BITS-1:0]   address;
    logic [2*BITS-1:0] data;
    logic              rd;
    logic              hlt;
    logic              error;
    logic              io_rd;
    logic              io_wr;
    logic [BITS-1:0]   io_address;
    wire  [BITS-1:0]   io_data;

    logic [2*BITS-1:0] flash [FLASH_DEPTH];
    logic [BITS-1:0]   io_table [16];     // io read data indexed by io_address[3:0]
    logic [BITS-1:0]   regs [8];          // model register file
    logic [31:0]       wr_log [$];        // {io_address, io_data} seen by the device
    logic [31:0]       exp_wr [$];        // writes predicted by the model

    // expected pin values per cycle from stage 0 of the first instruction on
    logic              t_rd     [TRACE_MAX];
    logic [BITS-1:0]   t_addr   [TRACE_MAX];
    logic              t_iord   [TRACE_MAX];
    logic              t_iowr   [TRACE_MAX];
    logic [BITS-1:0]   t_ioaddr [TRACE_MAX];
    logic              t_drv    [TRACE_MAX];
    logic [BITS-1:0]   t_wdata  [TRACE_MAX];
    logic              t_hlt    [TRACE_MAX];
    logic              t_err    [TRACE_MAX];
    int                tlen;

    integer seed = 14324;
    int     mismatch_count = 0;
    int     fail_count = 0;
    int     cur_prog;
    int     cur_cycle;

    tb_clk_gen #(.PERIOD_NS(100)) clk_gen_i (.clk(clk));

    cpu #(.BITS(BITS)) dut_i (
        .clk        (clk),
        .reset      (reset),
        .address    (address),
        .data       (data),
        .rd         (rd),
        .hlt        (hlt),
        .error      (error),
        .io_rd      (io_rd),
        .io_wr      (io_wr),
        .io_address (io_address),
        .io_data    (io_data)
    );

    assign data    = flash[address[5:0]];  // flash answers without delay
    assign io_data = io_rd ? {BITS{1'bz}} : io_table[io_address[3:0]];

    // device takes the write at the edge that ends the strobe cycle
    always @(posedge clk) begin
        if (reset && !io_wr) begin
            wr_log.push_back({io_address, io_data});
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("MISMATCH %s: got %h, expected %h (program %0d, cycle %0d)",
                     name, got, exp, cur_prog, cur_cycle);
        end
    endtask

    // forward jumps only with HLT last and maybe one illegal word before it
    task automatic gen_program(input bit with_illegal);
        int          n;
        int          ill;
        int          lim;
        logic [5:0]  opc;
        logic [15:0] imm;
        n   = 20 + rand_below(21);
        ill = with_illegal ? 1 + rand_below(n - 2) : n - 1;
        for (int i = 0; i < FLASH_DEPTH; i++) begin
            flash[i] = {16'h0000, 16'(i)};  // nop with its own address as imm
        end
        for (int i = 0; i < n - 1; i++) begin
            opc = 6'(2 + rand_below(16));
            if (opc == 6'h11) opc = cpu_pkg::OPC_NOP;
            if (i == ill) opc = 6'(6'h11 + rand_below(47));
            lim = (i < ill) ? ill : n - 1;  // never jump over the illegal word
            imm = 16'($random(seed));
            if (opc inside {cpu_pkg::OPC_JMP, cpu_pkg::OPC_JZ, cpu_pkg::OPC_JC})
                imm = 16'(i + 1 + rand_below(lim - i));
            flash[i] = {opc, 3'(rand_below(8)), 3'(rand_below(8)), 4'h0, imm};
        end
        flash[n-1] = {cpu_pkg::OPC_HLT, 26'h0};
    endtask

    // isa model filling the cycle trace and the expected io writes
    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] npc;
        logic [15:0] imm;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic [5:0]  opc;
        logic [2:0]  rdi;
        logic        cf;
        logic        zf;
        logic        alu_op;
        logic        done;
        logic        ill;
        int          ncyc;
        pc   = '0;
        cf   = 1'b0;
        zf   = 1'b0;
        done = 1'b0;
        ill  = 1'b0;
        tlen = 0;
        exp_wr.delete();
        for (int r = 0; r < 8; r++) regs[r] = '0;
        while (!done) begin
            opc  = flash[pc[5:0]][31:26];
            rdi  = flash[pc[5:0]][25:23];
            imm  = flash[pc[5:0]][15:0];
            a    = regs[rdi];
            b    = regs[flash[pc[5:0]][22:20]];
            ncyc = (opc == cpu_pkg::OPC_IN) ? 4 : (opc == cpu_pkg::OPC_OUT) ? 5 : 3;
            for (int s = 0; s < ncyc; s++) begin
                t_rd[tlen]     = (s > 1);  // fetch in stages 0 and 1
                t_addr[tlen]   = pc;
                t_iord[tlen]   = !(opc == cpu_pkg::OPC_IN && (s == 1 || s == 2));
                t_iowr[tlen]   = !(opc == cpu_pkg::OPC_OUT && s == 3);
                t_drv[tlen]    = (opc == cpu_pkg::OPC_OUT && s >= 3);
                t_ioaddr[tlen] = imm;
                t_wdata[tlen]  = a;
                t_hlt[tlen]    = 1'b0;
                t_err[tlen]    = 1'b0;
                tlen++;
            end
            npc    = pc + 16'd1;
            alu_op = 1'b1;
            res    = '0;
            case (opc)
                cpu_pkg::OPC_MOVI: {cf, res} = {1'b0, imm};
                cpu_pkg::OPC_MOV:  {cf, res} = {1'b0, b};
                cpu_pkg::OPC_ADD:  {cf, res} = {1'b0, a} + {1'b0, b};
                cpu_pkg::OPC_SUB: begin
                    res = a - b;
                    cf  = (a < b);  // borrow
                end
                cpu_pkg::OPC_AND:  {cf, res} = {1'b0, a & b};
                cpu_pkg::OPC_OR:   {cf, res} = {1'b0, a | b};
                cpu_pkg::OPC_XOR:  {cf, res} = {1'b0, a ^ b};
                cpu_pkg::OPC_SHL:  {cf, res} = {a, 1'b0};  // msb into carry
                cpu_pkg::OPC_SHR:  {res, cf} = {1'b0, a};  // lsb into carry
                cpu_pkg::OPC_ADDI: {cf, res} = {1'b0, a} + {1'b0, imm};
                default: begin
                    alu_op = 1'b0;
                    case (opc)
                        cpu_pkg::OPC_NOP: ;
                        cpu_pkg::OPC_HLT: done = 1'b1;
                        cpu_pkg::OPC_IN:  regs[rdi] = io_table[imm[3:0]];
                        cpu_pkg::OPC_OUT: exp_wr.push_back({imm, a});
                        cpu_pkg::OPC_JMP: npc = imm;
                        cpu_pkg::OPC_JZ:  if (zf) npc = imm;
                        cpu_pkg::OPC_JC:  if (cf) npc = imm;
                        default: begin
                            done = 1'b1;
                            ill  = 1'b1;
                        end
                    endcase
                end
            endcase
            if (alu_op) begin
                regs[rdi] = res;
                zf        = (res == '0);
            end
            if (!done) pc = npc;
        end
        // everything quiet while halted until the next reset
        for (int k = 0; k < HALT_WIN; k++) begin
            t_rd[tlen]   = 1'b1;
            t_iord[tlen] = 1'b1;
            t_iowr[tlen] = 1'b1;
            t_drv[tlen]  = 1'b0;
            t_hlt[tlen]  = 1'b1;
            t_err[tlen]  = ill;
            tlen++;
        end
    endtask

    task automatic check_cycle(input int i);
        cur_cycle = i;
        check_value("rd", rd, t_rd[i]);
        check_value("io_rd", io_rd, t_iord[i]);
        check_value("io_wr", io_wr, t_iowr[i]);
        check_value("hlt", hlt, t_hlt[i]);
        check_value("error", error, t_err[i]);
        if (!t_rd[i]) check_value("address", address, t_addr[i]);
        if (!t_iord[i] || !t_iowr[i]) check_value("io_address", io_address, t_ioaddr[i]);
        if (t_drv[i])
            check_value("io_data", io_data, t_wdata[i]);
        else if (t_iord[i])
            check_value("io_data", io_data, 32'h0000zzzz);  // bus released
        else
            check_value("io_data", io_data, io_table[t_ioaddr[i][3:0]]);  // device only
    endtask

    task automatic check_writes();
        assert (wr_log.size() == exp_wr.size()) else begin
            fail_count++;
            $display("program %0d: device saw %0d io writes, model expects %0d",
                     cur_prog, wr_log.size(), exp_wr.size());
        end
        for (int k = 0; k < wr_log.size() && k < exp_wr.size(); k++) begin
            check_value("io write {io_address, io_data}", wr_log[k], exp_wr[k]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all programs finished");
        $display("errors: %0d mismatches, %0d other failures", mismatch_count,
                 fail_count + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset = 1'b0;
        for (int k = 0; k < 16; k++) io_table[k] = 16'($random(seed));
        for (int p = 0; p < NUM_PROGS; p++) begin
            cur_prog = p;
            gen_program(p == NUM_PROGS - 1);
            run_model();
            wr_log.delete();
            @(negedge clk);
            reset    = 1'b0;  // each program restarts from address 0
            repeat (3) @(negedge clk);
            reset = 1'b1;
            // stage 0 of the first word overlaps the reset release so checks start at stage 1
            for (int i = 1; i < tlen; i++) begin
                @(negedge clk);
                check_cycle(i);
            end
            check_writes();
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // 50/50 duty
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

// stage   rd  io_rd  io_wr  io_data   used by
//   0     0   1      1      z         all, fetch
//   1     0   0(in)  1      z         all, decode
//   2     1   0(in)  1      z         all, alu / io sample / out latch
//   3     1   1      0(out) out data  in write back, out strobe
//   4     1   1      1      out data  out hold

module cpu #(
    parameter int BITS = 16
) (
    input  logic                clk,
    input  logic                reset,
    output logic [BITS-1:0]     address,
    input  logic [2*BITS-1:0]   data,
    output logic                rd,
    output logic                hlt,
    output logic                error,
    output logic                io_rd,
    output logic                io_wr,
    output logic [BITS-1:0]     io_address,
    inout  wire  [BITS-1:0]     io_data
);

    logic [cpu_pkg::STAGE_W-1:0]    stage;
    logic [cpu_pkg::STAGE_W-1:0]    max_stage;
    logic                           alu_en;
    cpu_pkg::alu_op_t               alu_op;
    logic [BITS-1:0]                alu_op1;
    logic [BITS-1:0]                alu_op2;
    logic [BITS-1:0]                alu_out;
    logic                           c;
    logic                           z;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_rd_addr_a;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_rd_addr_b;
    logic [BITS-1:0]                rf_rd_data_a;
    logic [BITS-1:0]                rf_rd_data_b;
    logic                           rf_wr_en;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_wr_addr;
    logic [BITS-1:0]                rf_wr_data;
    logic [BITS-1:0]                io_data_out;
    logic                           io_data_dir;

    // stage counter, wraps after max_stage, frozen once halted
    always_ff @(posedge clk) begin
        if (!reset) begin
            stage <= '0;
        end else if (!hlt) begin
            stage <= (stage == max_stage) ? '0 : stage + 1'b1;
        end
    end

    // flash read in stages 0 and 1
    assign rd = ~reset | hlt | (stage > 3'd1);

    assign io_data = io_data_dir ? io_data_out : {BITS{1'bz}};  // released unless writing

    idecoder #(.BITS(BITS)) idecoder_i (
        .clk          (clk),
        .reset        (reset),
        .stage        (stage),
        .data         (data),
        .io_data_in   (io_data),
        .alu_out      (alu_out),
        .c            (c),
        .z            (z),
        .rf_rd_data_a (rf_rd_data_a),
        .rf_rd_data_b (rf_rd_data_b),
        .address      (address),
        .io_address   (io_address),
        .io_rd        (io_rd),
        .io_wr        (io_wr),
        .io_data_out  (io_data_out),
        .io_data_dir  (io_data_dir),
        .max_stage    (max_stage),
        .alu_en       (alu_en),
        .alu_op       (alu_op),
        .alu_op1      (alu_op1),
        .alu_op2      (alu_op2),
        .rf_rd_addr_a (rf_rd_addr_a),
        .rf_rd_addr_b (rf_rd_addr_b),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_addr   (rf_wr_addr),
        .rf_wr_data   (rf_wr_data),
        .hlt          (hlt),
        .error        (error)
    );

    alu #(.BITS(BITS)) alu_i (
        .clk   (clk),
        .reset (reset),
        .en    (alu_en),
        .op    (alu_op),
        .op1   (alu_op1),
        .op2   (alu_op2),
        .out   (alu_out),
        .c     (c),
        .z     (z)
    );

    register_file #(
        .BITS     (BITS),
        .NUM_REGS (cpu_pkg::NUM_REGS)
    ) register_file_i (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (rf_wr_en),
        .wr_addr   (rf_wr_addr),
        .wr_data   (rf_wr_data),
        .rd_addr_a (rf_rd_addr_a),
        .rd_addr_b (rf_rd_addr_b),
        .rd_data_a (rf_rd_data_a),
        .rd_data_b (rf_rd_data_b)
    );

endmodule

//--- idecoder.sv
`timescale 1ns/1ps

module idecoder #(
    parameter int BITS = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpu_pkg::STAGE_W-1:0]     stage,
    input  logic [2*BITS-1:0]               data,         // flash word
    input  logic [BITS-1:0]                 io_data_in,
    input  logic [BITS-1:0]                 alu_out,
    input  logic                            c,
    input  logic                            z,
    input  logic [BITS-1:0]                 rf_rd_data_a,
    input  logic [BITS-1:0]                 rf_rd_data_b,
    output logic [BITS-1:0]                 address,
    output logic [BITS-1:0]                 io_address,
    output logic                            io_rd,        // active low
    output logic                            io_wr,        // active low
    output logic [BITS-1:0]                 io_data_out,
    output logic                            io_data_dir,  // 1 = cpu drives io_data
    output logic [cpu_pkg::STAGE_W-1:0]     max_stage,
    output logic                            alu_en,
    output cpu_pkg::alu_op_t                alu_op,
    output logic [BITS-1:0]                 alu_op1,
    output logic [BITS-1:0]                 alu_op2,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  rf_rd_addr_a,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  rf_rd_addr_b,
    output logic                            rf_wr_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  rf_wr_addr,
    output logic [BITS-1:0]                 rf_wr_data,
    output logic                            hlt,
    output logic                            error
);

    localparam int OPC_LSB = 2*BITS - cpu_pkg::OPC_LSB_OFS;
    localparam int RD_LSB  = 2*BITS - cpu_pkg::RD_LSB_OFS;
    localparam int RS_LSB  = 2*BITS - cpu_pkg::RS_LSB_OFS;

    logic [BITS-1:0]   pc;
    logic [2*BITS-1:0] ir;        // instruction register
    logic [2*BITS-1:0] instr;     // word being decoded this stage
    logic [BITS-1:0]   imm;
    logic [BITS-1:0]   io_in_q;   // io read data
    cpu_pkg::opcode_t  opcode;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd_field;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs_field;

    // decode results
    logic use_imm;     // op2 from immediate
    logic alu_instr;   // writes alu result and flags
    logic is_in;
    logic is_out;
    logic is_halt;
    logic is_illegal;
    logic jump_taken;
    logic last_stage;

    // flash word is live in stage 1, ir holds it afterwards
    assign instr    = (stage == 3'd1) ? data : ir;
    assign opcode   = cpu_pkg::opcode_t'(instr[OPC_LSB +: cpu_pkg::OPCODE_W]);
    assign rd_field = instr[RD_LSB +: cpu_pkg::REG_ADDR_W];
    assign rs_field = instr[RS_LSB +: cpu_pkg::REG_ADDR_W];
    assign imm      = instr[BITS-1:0];

    always_comb begin
        max_stage  = cpu_pkg::LAST_STAGE_REG;
        alu_op     = cpu_pkg::ALU_PASS_B;
        use_imm    = 1'b0;
        alu_instr  = 1'b0;
        is_in      = 1'b0;
        is_out     = 1'b0;
        is_halt    = 1'b0;
        is_illegal = 1'b0;
        jump_taken = 1'b0;
        case (opcode)
            cpu_pkg::OPC_NOP: ;
            cpu_pkg::OPC_HLT: is_halt = 1'b1;
            cpu_pkg::OPC_MOVI: begin
                alu_instr = 1'b1;
                use_imm   = 1'b1;  // pass_b of imm
            end
            cpu_pkg::OPC_MOV: alu_instr = 1'b1;
            cpu_pkg::OPC_ADD: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_ADD;
            end
            cpu_pkg::OPC_SUB: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_SUB;
            end
            cpu_pkg::OPC_AND: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_AND;
            end
            cpu_pkg::OPC_OR: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_OR;
            end
            cpu_pkg::OPC_XOR: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_XOR;
            end
            cpu_pkg::OPC_SHL: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_SHL;
            end
            cpu_pkg::OPC_SHR: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_SHR;
            end
            cpu_pkg::OPC_ADDI: begin
                alu_instr = 1'b1;
                alu_op    = cpu_pkg::ALU_ADD;
                use_imm   = 1'b1;
            end
            cpu_pkg::OPC_IN: begin
                is_in     = 1'b1;
                max_stage = cpu_pkg::LAST_STAGE_IN;
            end
            cpu_pkg::OPC_OUT: begin
                is_out    = 1'b1;
                max_stage = cpu_pkg::LAST_STAGE_OUT;
            end
            cpu_pkg::OPC_JMP: jump_taken = 1'b1;
            cpu_pkg::OPC_JZ:  jump_taken = z;  // flags from last alu op
            cpu_pkg::OPC_JC:  jump_taken = c;
            default: is_illegal = 1'b1;
        endcase
    end

    assign last_stage = (stage == max_stage);

    // flash side
    assign address = pc;

    // io strobes, all active low
    assign io_address  = imm;  // valid from stage 1 on
    assign io_rd       = ~(is_in && (stage == 3'd1 || stage == 3'd2));
    assign io_wr       = ~(is_out && stage == 3'd3);
    assign io_data_dir = is_out && (stage == 3'd3 || stage == 3'd4);  // write plus hold

    // alu hookup
    assign rf_rd_addr_a = rd_field;
    assign rf_rd_addr_b = rs_field;
    assign alu_op1      = rf_rd_data_a;
    assign alu_op2      = use_imm ? imm : rf_rd_data_b;
    assign alu_en       = alu_instr && stage == 3'd2;

    // write back, alu at end of stage 2, io read at end of stage 3
    assign rf_wr_en   = (alu_instr && stage == 3'd2) || (is_in && stage == 3'd3);
    assign rf_wr_addr = rd_field;
    assign rf_wr_data = is_in ? io_in_q : alu_out;

    // payload latches
    always_ff @(posedge clk) begin
        if (stage == 3'd1) begin
            ir <= data;
        end
        if (stage == 3'd2 && is_in) begin
            io_in_q <= io_data_in;   // device drives while io_rd low
        end
        if (stage == 3'd2 && is_out) begin
            io_data_out <= rf_rd_data_a;
        end
    end

    // pc and halt state
    always_ff @(posedge clk) begin
        if (!reset) begin
            pc    <= '0;
            hlt   <= 1'b0;
            error <= 1'b0;
        end else begin
            if (stage == 3'd2 && (is_halt || is_illegal)) begin
                hlt   <= 1'b1;         // sticky until reset
                error <= is_illegal;
            end else if (last_stage && !hlt) begin
                pc <= jump_taken ? imm : pc + 1'b1;  // pc stays on halt
            end
        end
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int BITS     = 16,
    parameter int NUM_REGS = cpu_pkg::NUM_REGS
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr_en,
    input  logic [$clog2(NUM_REGS)-1:0] wr_addr,
    input  logic [BITS-1:0]             wr_data,
    input  logic [$clog2(NUM_REGS)-1:0] rd_addr_a,
    input  logic [$clog2(NUM_REGS)-1:0] rd_addr_b,
    output logic [BITS-1:0]             rd_data_a,
    output logic [BITS-1:0]             rd_data_b
);

    logic [BITS-1:0] regs [NUM_REGS];

    // write port, all registers start at zero
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read ports are async, no bypass from the write port
    assign rd_data_a = regs[rd_addr_a];  // rd field, alu op1 / out data
    assign rd_data_b = regs[rd_addr_b];  // rs field

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int BITS = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,   // flag update strobe
    input  cpu_pkg::alu_op_t       op,
    input  logic [BITS-1:0]        op1,  // rd value
    input  logic [BITS-1:0]        op2,  // rs value or immediate
    output logic [BITS-1:0]        out,
    output logic                   c,
    output logic                   z
);

    logic [BITS:0] wide;      // result with carry / borrow on top
    logic          carry_nxt;

    always_comb begin
        wide      = '0;
        carry_nxt = 1'b0;
        case (op)
            cpu_pkg::ALU_PASS_B: wide = {1'b0, op2};
            cpu_pkg::ALU_ADD: begin
                wide      = {1'b0, op1} + {1'b0, op2};
                carry_nxt = wide[BITS];
            end
            cpu_pkg::ALU_SUB: begin
                wide      = {1'b0, op1} - {1'b0, op2};
                carry_nxt = wide[BITS];  // borrow
            end
            cpu_pkg::ALU_AND: wide = {1'b0, op1 & op2};
            cpu_pkg::ALU_OR:  wide = {1'b0, op1 | op2};
            cpu_pkg::ALU_XOR: wide = {1'b0, op1 ^ op2};
            cpu_pkg::ALU_SHL: begin
                wide      = {1'b0, op1[BITS-2:0], 1'b0};
                carry_nxt = op1[BITS-1];  // msb shifted out
            end
            cpu_pkg::ALU_SHR: begin
                wide      = {2'b00, op1[BITS-1:1]};
                carry_nxt = op1[0];       // lsb shifted out
            end
            default: begin
                wide      = '0;  // unused encodings give zero
                carry_nxt = 1'b0;
            end
        endcase
    end

    assign out = wide[BITS-1:0];

    // flags only move on en, so jumps see the last alu result
    always_ff @(posedge clk) begin
        if (!reset) begin
            c <= 1'b0;
            z <= 1'b0;
        end else if (en) begin
            c <= carry_nxt;
            z <= (out == '0);
        end
    end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    // instruction field widths
    localparam int OPCODE_W   = 6;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;

    // field lsb positions, counted down from the top of the 2*BITS word
    // lsb index of a field = 2*BITS - *_LSB_OFS
    localparam int OPC_LSB_OFS = 6;   // opcode in the top 6 bits
    localparam int RD_LSB_OFS  = 9;   // destination register below it
    localparam int RS_LSB_OFS  = 12;  // source register below that
    // rest of the upper half is unused, lower half is imm / io addr / target

    // stage counter
    localparam int STAGE_W = 3;
    localparam logic [STAGE_W-1:0] LAST_STAGE_REG = 3'd2;  // fetch, decode, alu
    localparam logic [STAGE_W-1:0] LAST_STAGE_IN  = 3'd3;  // one extra for io read
    localparam logic [STAGE_W-1:0] LAST_STAGE_OUT = 3'd4;  // write strobe plus hold

    typedef enum logic [OPCODE_W-1:0] {
        OPC_NOP  = 6'h00,
        OPC_HLT  = 6'h01,
        OPC_MOVI = 6'h02,  // rd = imm
        OPC_MOV  = 6'h03,  // rd = rs
        OPC_ADD  = 6'h04,  // rd = rd + rs
        OPC_SUB  = 6'h05,  // rd = rd - rs
        OPC_AND  = 6'h06,
        OPC_OR   = 6'h07,
        OPC_XOR  = 6'h08,
        OPC_SHL  = 6'h09,  // rd = rd << 1
        OPC_SHR  = 6'h0a,  // rd = rd >> 1
        OPC_ADDI = 6'h0b,  // rd = rd + imm
        OPC_IN   = 6'h0c,  // rd = io[imm]
        OPC_OUT  = 6'h0d,  // io[imm] = rd
        OPC_JMP  = 6'h0e,
        OPC_JZ   = 6'h0f,
        OPC_JC   = 6'h10
        // anything above 6'h10 is illegal
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_PASS_B = 4'h0,
        ALU_ADD    = 4'h1,
        ALU_SUB    = 4'h2,
        ALU_AND    = 4'h3,
        ALU_OR     = 4'h4,
        ALU_XOR    = 4'h5,
        ALU_SHL    = 4'h6,
        ALU_SHR    = 4'h7
    } alu_op_t;

endpackage
